/* pa_settings.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths of the P-A unit, included by the packages and RTL
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PA_SETTINGS_SVH
`define PA_SETTINGS_SVH

`define PA_WIDTH     16
`define PA_SLICE     4
`define PA_KEY_WIDTH 16

`endif

/* pa_data_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data-side types, the machine word and ALU function/flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pa_settings.svh"

package pa_data_pkg;

	// bit 0 is the MSB, as on the schematics
	typedef logic [0:`PA_WIDTH-1] pa_word_t;

	// 74181 function code
	typedef struct packed {
		logic [3:0] s;
		logic       m;    // high selects logic mode
	} pa_alu_fn_t;

	typedef struct packed {
		logic s0;         // result MSB
		logic carry;      // true carry out of bit 0
		logic eq;
		logic exx;        // shift-in bit picked by ir[6]
		logic zero;
	} pa_alu_flags_t;

endpackage

/* pa_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control-side types: micro-orders, strobes, bus selects
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pa_ctrl_pkg;

	typedef enum logic [2:0] {
		WSEL_IR  = 3'd0,
		WSEL_KL  = 3'd1,
		WSEL_RDT = 3'd2,
		WSEL_ACH = 3'd3,  // high byte zero, ac high byte into low byte
		WSEL_KI  = 3'd4,
		WSEL_AT  = 3'd5,
		WSEL_AC  = 3'd6,
		WSEL_A   = 3'd7
	} pa_wsel_t;

	typedef enum logic [1:0] {
		ASEL_L   = 2'd0,
		ASEL_AR  = 2'd1,
		ASEL_IC  = 2'd2,
		ASEL_LIR = 2'd3   // l low byte on top, ir low byte below
	} pa_asel_t;

	typedef struct packed {
		logic strob1;
		logic strob2;
		logic as2;
	} pa_strobe_t;

	typedef struct packed {
		pa_wsel_t wsel;
		logic     w_hi_clr;
		logic     w_lo_clr;
		pa_asel_t asel;
		logic     a_hi_clr;
		logic     a_mid_clr;
		logic     a_lo_clr;
		logic     w_dt;
	} pa_bus_ctrl_t;

	typedef struct packed {
		logic w_ac;
		logic w_ar;
		logic w_ic;
		logic arp1;
		logic arm4;
		logic icp1;
		logic ic_clr;
		logic at_load;
		logic at_shift;
		logic eat0;
		logic axy;
		logic am1;
		logic apb;
		logic amb;
		logic ap1;
		logic ar_ad;
		logic ic_ad;
		logic barnb;
	} pa_reg_ctrl_t;

	// register write phase: stroba or strobb
	function automatic logic write_phase(input pa_strobe_t st);
		return (st.strob1 & ~st.as2) | (st.strob2 & st.as2);
	endfunction

endpackage

/* alu181.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one 74181 ALU slice, active-high data and true carry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pa_settings.svh"

module alu181 (
	input  logic [`PA_SLICE-1:0] a,
	input  logic [`PA_SLICE-1:0] b,
	input  logic [3:0]           s,
	input  logic                 m,
	input  logic                 cn,
	output logic [`PA_SLICE-1:0] f,
	output logic                 eq,
	output logic                 p,
	output logic                 g,
	output logic                 cn4
);

	// arithmetic is x + y + cn, and y never has a bit that x lacks
	logic [`PA_SLICE-1:0] x;
	logic [`PA_SLICE-1:0] y;
	logic [`PA_SLICE:0]   c;

	assign x = a | (b & {`PA_SLICE{s[0]}}) | (~b & {`PA_SLICE{s[1]}});
	assign y = (a & ~b & {`PA_SLICE{s[2]}}) | (a & b & {`PA_SLICE{s[3]}});

	// ripple inside the slice
	always_comb begin
		c[0] = cn;
		for (int i = 0; i < `PA_SLICE; i++) begin
			c[i + 1] = y[i] | (x[i] & c[i]);
		end
	end

	// group generate, independent of cn
	always_comb begin
		g = 1'b0;
		for (int i = 0; i < `PA_SLICE; i++) begin
			g = y[i] | (x[i] & g);
		end
	end

	assign p   = &x;
	assign cn4 = c[`PA_SLICE];

	// logic mode drops the carries
	assign f  = m ? ~(x ^ y) : (x ^ y ^ c[`PA_SLICE-1:0]);
	assign eq = &f;

endmodule

/* pa_alu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-bit ALU, four 181 slices with 182-style look-ahead
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pa_settings.svh"

module pa_alu import pa_data_pkg::*; (
	input  pa_word_t      a,
	input  pa_word_t      b,
	input  pa_alu_fn_t    fn,
	input  logic          cin,
	input  logic          ir6,
	output pa_word_t      f,
	output pa_alu_flags_t flags
);

	localparam int NSLICE = `PA_WIDTH / `PA_SLICE;

	// slice 0 holds the most significant bits
	logic [0:NSLICE-1] g;
	logic [0:NSLICE-1] p;
	logic [0:NSLICE-1] eq;
	logic [0:NSLICE-1] c;

	for (genvar i = 0; i < NSLICE; i++) begin : g_slice
		alu181 u_slice (
			.a   (a[i*`PA_SLICE +: `PA_SLICE]),
			.b   (b[i*`PA_SLICE +: `PA_SLICE]),
			.s   (fn.s),
			.m   (fn.m),
			.cn  (c[i]),
			.f   (f[i*`PA_SLICE +: `PA_SLICE]),
			.eq  (eq[i]),
			.p   (p[i]),
			.g   (g[i]),
			.cn4 ()
		);
	end

	// look-ahead carries into the upper slices
	assign c[3] = cin;
	assign c[2] = g[3] | (p[3] & cin);
	assign c[1] = g[2] | (p[2] & g[3]) | (p[2] & p[3] & cin);
	assign c[0] = g[1] | (p[1] & g[2]) | (p[1] & p[2] & g[3]) | (p[1] & p[2] & p[3] & cin);

	assign flags.carry = g[0] | (p[0] & c[0]);
	assign flags.s0    = f[0];
	assign flags.eq    = &eq;
	assign flags.zero  = ~|f;
	assign flags.exx   = ir6 ? a[15] : a[0];

endmodule

/* pa_at_reg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AT register, loads the ALU result or shifts right
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pa_at_reg
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;
(
	input  logic         __clk,
	input  logic         rst_n,
	input  pa_strobe_t   strobe,
	input  pa_reg_ctrl_t ctrl,
	input  pa_word_t     f,
	input  logic         a0,
	output pa_word_t     at,
	output logic         at15,
	output logic         exy
);

	logic at_en;

	// strob1 in the as2 phase
	assign at_en = strobe.strob1 & strobe.as2;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			at <= '0;
		end else if (at_en) begin
			if (ctrl.at_load) begin
				at <= f;
			end else if (ctrl.at_shift) begin
				// toward bit 15, eat0 fills the MSB
				at <= {ctrl.eat0, at[0:14]};
			end
		end
	end

	assign at15 = at[15];
	assign exy  = ctrl.axy ? at[15] : a0;

endmodule

/* pa_ac_flags.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AC accumulator, sign extension bit, zero detect, WZI
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pa_ac_flags
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;
(
	input  logic         __clk,
	input  logic         rst_n,
	input  pa_strobe_t   strobe,
	input  pa_reg_ctrl_t ctrl,
	input  pa_word_t     w,
	input  logic         a0,
	input  logic         f_zero,
	input  logic         carry,
	output pa_word_t     ac,
	output logic         s_1,
	output logic         zs,
	output logic         wzi
);

	logic ac_we;
	logic wzi_en;
	logic ext;

	assign ac_we  = ctrl.w_ac & write_phase(strobe);
	assign wzi_en = strobe.strob1 & strobe.as2;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			ac <= '0;
		end else if (ac_we) begin
			ac <= w;
		end
	end

	// extension bit above the MSB, per operation
	assign ext = (~a0 & ctrl.am1) | ((ac[0] ^ a0) & ctrl.apb)
		| (~(ac[0] ^ a0) & ctrl.amb) | (a0 & ctrl.ap1);
	assign s_1 = ext ^ carry;

	// 17-bit result is zero
	assign zs = ~s_1 & f_zero;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			wzi <= 1'b0;
		end else if (wzi_en) begin
			wzi <= zs;
		end
	end

endmodule

/* pa_addr_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AR and IC counters, the address bus and key compare
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pa_settings.svh"

module pa_addr_regs
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;
(
	input  logic         __clk,
	input  logic         rst_n,
	input  pa_strobe_t   strobe,
	input  pa_reg_ctrl_t ctrl,
	input  pa_word_t     w,
	input  pa_word_t     kl,
	output pa_word_t     ar,
	output pa_word_t     ic,
	output pa_word_t     dad,
	output logic         arz,
	output logic         zga
);

	logic                      ar_we;
	logic                      ic_we;
	pa_word_t                  addr;
	logic [0:`PA_KEY_WIDTH-1]  key;

	assign ar_we = ctrl.w_ar & write_phase(strobe);
	assign ic_we = ctrl.w_ic & write_phase(strobe);

	// load beats counting
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			ar <= '0;
		end else if (ar_we) begin
			ar <= w;
		end else if (strobe.strob1 & ctrl.arp1) begin
			ar <= ar + pa_word_t'(1);
		end else if (strobe.strob1 & ctrl.arm4) begin
			ar <= ar - pa_word_t'(4);
		end
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			ic <= '0;
		end else if (ctrl.ic_clr) begin
			ic <= '0;
		end else if (ic_we) begin
			ic <= w;
		end else if (strobe.strob1 & ctrl.icp1) begin
			ic <= ic + pa_word_t'(1);
		end
	end

	// address bus, driven active low
	assign addr = (ar & {`PA_WIDTH{ctrl.ar_ad}}) | (ic & {`PA_WIDTH{ctrl.ic_ad}});
	assign dad  = ~addr;

	// barnb takes the place of the top address bit
	assign key = {ctrl.barnb, addr[1:`PA_KEY_WIDTH-1]};
	assign zga = (kl == key);

	assign arz = |ar[0:7];

endmodule

/* pa_bus.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// W and A multiplexers, with the inverted data-bus driver
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pa_bus
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;
(
	input  pa_bus_ctrl_t ctrl,
	input  pa_word_t     ir,
	input  pa_word_t     kl,
	input  pa_word_t     ki,
	input  pa_word_t     rdt,
	input  pa_word_t     ac,
	input  pa_word_t     at,
	input  pa_word_t     ar,
	input  pa_word_t     ic,
	input  pa_word_t     l,
	output pa_word_t     w,
	output pa_word_t     a,
	output pa_word_t     ddt
);

	pa_word_t w_src;
	pa_word_t a_src;

	always_comb begin
		case (ctrl.wsel)
			WSEL_IR:  w_src = ir;
			WSEL_KL:  w_src = kl;
			WSEL_RDT: w_src = rdt;
			// byte move, ac high byte lands in the low half
			WSEL_ACH: w_src = {8'h00, ac[0:7]};
			WSEL_KI:  w_src = ki;
			WSEL_AT:  w_src = at;
			WSEL_AC:  w_src = ac;
			default:  w_src = a;
		endcase
	end

	// each half has its own clear
	assign w = {ctrl.w_hi_clr ? 8'h00 : w_src[0:7], ctrl.w_lo_clr ? 8'h00 : w_src[8:15]};

	always_comb begin
		case (ctrl.asel)
			ASEL_L:  a_src = l;
			ASEL_AR: a_src = ar;
			ASEL_IC: a_src = ic;
			default: a_src = {l[8:15], ir[8:15]};
		endcase
	end

	// clear groups follow the instruction fields
	assign a = {ctrl.a_hi_clr  ? 8'h00 : a_src[0:7],
		ctrl.a_mid_clr ? 2'b00 : a_src[8:9],
		ctrl.a_lo_clr  ? 6'h00 : a_src[10:15]};

	// data bus is active low and idles high
	assign ddt = ctrl.w_dt ? ~w : '1;

endmodule

/* pa.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-A arithmetic and register unit, top level wiring
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pa
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;
(
	input  logic          __clk,
	input  logic          rst_n,
	input  pa_bus_ctrl_t  bus_ctrl,
	input  pa_reg_ctrl_t  reg_ctrl,
	input  pa_strobe_t    strobe,
	input  pa_alu_fn_t    fn,
	input  logic          cin,
	input  pa_word_t      ir,
	input  pa_word_t      kl,
	input  pa_word_t      ki,
	input  pa_word_t      rdt,
	input  pa_word_t      l,
	output pa_word_t      w,
	output pa_word_t      ddt,
	output pa_word_t      dad,
	output pa_alu_flags_t flags,
	output logic          at15,
	output logic          exy,
	output logic          s_1,
	output logic          zs,
	output logic          wzi,
	output logic          arz,
	output logic          zga,
	output pa_word_t      ac,
	output pa_word_t      ar,
	output pa_word_t      ic
);

	pa_word_t a;
	pa_word_t f;
	pa_word_t at;

	pa_bus u_bus (
		.ctrl (bus_ctrl),
		.ir   (ir),
		.kl   (kl),
		.ki   (ki),
		.rdt  (rdt),
		.ac   (ac),
		.at   (at),
		.ar   (ar),
		.ic   (ic),
		.l    (l),
		.w    (w),
		.a    (a),
		.ddt  (ddt)
	);

	// A on the left operand, AC on the right
	pa_alu u_alu (
		.a     (a),
		.b     (ac),
		.fn    (fn),
		.cin   (cin),
		.ir6   (ir[6]),
		.f     (f),
		.flags (flags)
	);

	pa_at_reg u_at (
		.__clk  (__clk),
		.rst_n  (rst_n),
		.strobe (strobe),
		.ctrl   (reg_ctrl),
		.f      (f),
		.a0     (a[0]),
		.at     (at),
		.at15   (at15),
		.exy    (exy)
	);

	pa_ac_flags u_ac (
		.__clk  (__clk),
		.rst_n  (rst_n),
		.strobe (strobe),
		.ctrl   (reg_ctrl),
		.w      (w),
		.a0     (a[0]),
		.f_zero (flags.zero),
		.carry  (flags.carry),
		.ac     (ac),
		.s_1    (s_1),
		.zs     (zs),
		.wzi    (wzi)
	);

	pa_addr_regs u_addr (
		.__clk  (__clk),
		.rst_n  (rst_n),
		.strobe (strobe),
		.ctrl   (reg_ctrl),
		.w      (w),
		.kl     (kl),
		.ar     (ar),
		.ic     (ic),
		.dad    (dad),
		.arz    (arz),
		.zga    (zga)
	);

endmodule

/* pa_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the P-A unit, drives micro-orders directly
// and checks the responses against a small reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pa_tb
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;
();

	// the tests need about 105 cycles
	localparam int MAX_CYCLES = 400;

	localparam pa_alu_fn_t FN_ADD  = {4'b1001, 1'b0};
	localparam pa_alu_fn_t FN_SUB  = {4'b0110, 1'b0};
	localparam pa_alu_fn_t FN_XOR  = {4'b0110, 1'b1};
	localparam pa_alu_fn_t FN_AND  = {4'b1011, 1'b1};
	localparam pa_alu_fn_t FN_PASS = {4'b1111, 1'b1};

	logic          __clk;
	logic          rst_n;
	pa_bus_ctrl_t  bus_ctrl;
	pa_reg_ctrl_t  reg_ctrl;
	pa_strobe_t    strobe;
	pa_alu_fn_t    fn;
	logic          cin;
	pa_word_t      ir;
	pa_word_t      kl;
	pa_word_t      ki;
	pa_word_t      rdt;
	pa_word_t      l;
	pa_word_t      w;
	pa_word_t      ddt;
	pa_word_t      dad;
	pa_alu_flags_t flags;
	logic          at15;
	logic          exy;
	logic          s_1;
	logic          zs;
	logic          wzi;
	logic          arz;
	logic          zga;
	pa_word_t      ac;
	pa_word_t      ar;
	pa_word_t      ic;

	// reference model of the registers
	pa_word_t      m_ac;
	pa_word_t      m_at;
	pa_word_t      m_ar;
	pa_word_t      m_ic;
	pa_word_t      model_addr;

	pa_word_t      av;
	pa_word_t      bv;
	pa_word_t      e;
	pa_word_t      addr;
	logic [16:0]   s17;
	logic [16:0]   u17;
	logic          ci;
	logic          fill;
	int            seed;
	int            errors;
	int            test_errors;
	int            tests;
	int            cycles = 0;

	pa uut (
		.__clk    (__clk),
		.rst_n    (rst_n),
		.bus_ctrl (bus_ctrl),
		.reg_ctrl (reg_ctrl),
		.strobe   (strobe),
		.fn       (fn),
		.cin      (cin),
		.ir       (ir),
		.kl       (kl),
		.ki       (ki),
		.rdt      (rdt),
		.l        (l),
		.w        (w),
		.ddt      (ddt),
		.dad      (dad),
		.flags    (flags),
		.at15     (at15),
		.exy      (exy),
		.s_1      (s_1),
		.zs       (zs),
		.wzi      (wzi),
		.arz      (arz),
		.zga      (zga),
		.ac       (ac),
		.ar       (ar),
		.ic       (ic)
	);

	initial __clk = 1'b0;
	always #20 __clk = ~__clk;

	always @(posedge __clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	// true address from the model registers and the gate orders
	assign model_addr = (m_ar & {16{reg_ctrl.ar_ad}}) | (m_ic & {16{reg_ctrl.ic_ad}});

	// mid-cycle, where inputs and registers have settled
	dad_gated_or: assert property (@(negedge __clk) disable iff (!rst_n)
		dad == ~model_addr)
	else begin
		$display("FAILED %0t dad is not the inverted gated OR of ar and ic", $time);
		test_errors++;
	end

	zga_key_match: assert property (@(negedge __clk) disable iff (!rst_n)
		zga == (kl == {reg_ctrl.barnb, model_addr[1:15]}))
	else begin
		$display("FAILED %0t zga does not match the key compare", $time);
		test_errors++;
	end

	arz_high_byte: assert property (@(negedge __clk) disable iff (!rst_n)
		arz == (m_ar[0:7] != 8'h00))
	else begin
		$display("FAILED %0t arz does not follow the high byte of ar", $time);
		test_errors++;
	end

	function automatic pa_word_t rand_word();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic logic rand_bit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic pa_word_t w_source(input pa_wsel_t sel, input pa_word_t a_val);
		case (sel)
			WSEL_IR:  return ir;
			WSEL_KL:  return kl;
			WSEL_RDT: return rdt;
			WSEL_ACH: return {8'h00, m_ac[0:7]};
			WSEL_KI:  return ki;
			WSEL_AT:  return m_at;
			WSEL_AC:  return m_ac;
			default:  return a_val;
		endcase
	endfunction

	function automatic pa_word_t a_source(input pa_asel_t sel);
		case (sel)
			ASEL_L:  return l;
			ASEL_AR: return m_ar;
			ASEL_IC: return m_ic;
			default: return {l[8:15], ir[8:15]};
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge __clk);
		#2;
	endtask

	task automatic check_word(input string what, input pa_word_t got, input pa_word_t exp);
		assert (got === exp) else begin
			$display("FAILED %0t %s: got %h, expected %h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("FAILED %0t %s: got %b, expected %b", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	task automatic clear_inputs();
		bus_ctrl = '0;
		reg_ctrl = '0;
		strobe   = '0;
		fn       = '0;
		cin      = 1'b0;
	endtask

	// v reaches W through kl, phase_b picks strobb over stroba
	task automatic write_word(input pa_word_t v, input logic to_ac, input logic to_ar,
			input logic to_ic, input logic phase_b);
		bus_ctrl.wsel     = WSEL_KL;
		bus_ctrl.w_hi_clr = 1'b0;
		bus_ctrl.w_lo_clr = 1'b0;
		kl                = v;
		reg_ctrl.w_ac     = to_ac;
		reg_ctrl.w_ar     = to_ar;
		reg_ctrl.w_ic     = to_ic;
		strobe.strob1     = ~phase_b;
		strobe.strob2     = phase_b;
		strobe.as2        = phase_b;
		next_cycle();
		reg_ctrl.w_ac = 1'b0;
		reg_ctrl.w_ar = 1'b0;
		reg_ctrl.w_ic = 1'b0;
		strobe        = '0;
		if (to_ac) m_ac = v;
		if (to_ar) m_ar = v;
		if (to_ic) m_ic = v;
	endtask

	task automatic at_step(input logic load, input logic shift, input logic eat);
		reg_ctrl.at_load  = load;
		reg_ctrl.at_shift = shift;
		reg_ctrl.eat0     = eat;
		strobe.strob1     = 1'b1;
		strobe.as2        = 1'b1;
		next_cycle();
		reg_ctrl.at_load  = 1'b0;
		reg_ctrl.at_shift = 1'b0;
		strobe            = '0;
	endtask

	task automatic count_step(input logic arp1, input logic arm4, input logic icp1,
			input logic ic_clr, input pa_strobe_t st);
		reg_ctrl.arp1   = arp1;
		reg_ctrl.arm4   = arm4;
		reg_ctrl.icp1   = icp1;
		reg_ctrl.ic_clr = ic_clr;
		strobe          = st;
		next_cycle();
		reg_ctrl.arp1   = 1'b0;
		reg_ctrl.arm4   = 1'b0;
		reg_ctrl.icp1   = 1'b0;
		reg_ctrl.ic_clr = 1'b0;
		strobe          = '0;
	endtask

	task automatic check_regs(input string name);
		#1;
		check_word($sformatf("%s ac", name), ac, m_ac);
		check_word($sformatf("%s ar", name), ar, m_ar);
		check_word($sformatf("%s ic", name), ic, m_ic);
		check_bit($sformatf("%s arz", name), arz, m_ar[0:7] != 8'h00);
	endtask

	// result goes into AT so that f can be read back on W
	task automatic alu_op(input string name, input pa_alu_fn_t code, input logic c_in,
			input pa_word_t exp_f, input logic arith, input logic exp_c, input logic exp_s1);
		logic exp_zs;
		fn  = code;
		cin = c_in;
		#1;
		exp_zs = ~exp_s1 & (exp_f == '0);
		check_bit($sformatf("%s s0", name), flags.s0, exp_f[0]);
		check_bit($sformatf("%s zero", name), flags.zero, exp_f == '0);
		if (arith) begin
			check_bit($sformatf("%s carry", name), flags.carry, exp_c);
			check_bit($sformatf("%s s_1", name), s_1, exp_s1);
			check_bit($sformatf("%s zs", name), zs, exp_zs);
		end
		at_step(1'b1, 1'b0, 1'b0);
		m_at = exp_f;
		bus_ctrl.wsel = WSEL_AT;
		#1;
		check_word($sformatf("%s f", name), w, exp_f);
		if (arith) begin
			check_bit($sformatf("%s wzi", name), wzi, exp_zs);
		end
	endtask

	initial begin
		seed        = 98730;
		errors      = 0;
		test_errors = 0;
		tests       = 0;
		rst_n       = 1'b0;
		clear_inputs();
		ir   = '0;
		kl   = '0;
		ki   = '0;
		rdt  = '0;
		l    = '0;
		m_ac = '0;
		m_at = '0;
		m_ar = '0;
		m_ic = '0;
		repeat (3) @(posedge __clk);
		#2;
		rst_n = 1'b1;

		bus_ctrl.wsel = WSEL_AT;
		check_regs("reset");
		check_word("reset at", w, '0);
		check_bit("reset wzi", wzi, 1'b0);
		check_word("reset ddt", ddt, 16'hffff);
		end_test("reset");

		write_word(rand_word(), 1'b1, 1'b0, 1'b0, 1'b0);
		write_word(rand_word(), 1'b0, 1'b1, 1'b0, 1'b0);
		write_word(rand_word(), 1'b0, 1'b0, 1'b1, 1'b1);
		l  = rand_word();
		fn = FN_PASS;
		at_step(1'b1, 1'b0, 1'b0);
		m_at = l;
		ir   = rand_word();
		ki   = rand_word();
		rdt  = rand_word();
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			bus_ctrl.wsel = pa_wsel_t'(i);
			for (int c = 0; c < 8; c++) begin
				bus_ctrl.w_hi_clr = c[2];
				bus_ctrl.w_lo_clr = c[1];
				bus_ctrl.w_dt     = c[0];
				#1;
				e = w_source(pa_wsel_t'(i), l);
				if (c[2]) e[0:7] = 8'h00;
				if (c[1]) e[8:15] = 8'h00;
				check_word($sformatf("w sel %0d clr %0d", i, c), w, e);
				check_word($sformatf("ddt sel %0d clr %0d", i, c), ddt, c[0] ? ~e : 16'hffff);
			end
		end
		bus_ctrl = '0;
		end_test("w bus");

		for (int i = 0; i < 4; i++) begin
			next_cycle();
			bus_ctrl.wsel = WSEL_A;
			bus_ctrl.asel = pa_asel_t'(i);
			for (int c = 0; c < 8; c++) begin
				bus_ctrl.a_hi_clr  = c[2];
				bus_ctrl.a_mid_clr = c[1];
				bus_ctrl.a_lo_clr  = c[0];
				#1;
				e = a_source(pa_asel_t'(i));
				if (c[2]) e[0:7] = 8'h00;
				if (c[1]) e[8:9] = 2'b00;
				if (c[0]) e[10:15] = 6'h00;
				check_word($sformatf("a sel %0d clr %0d", i, c), w, e);
			end
		end
		bus_ctrl = '0;
		end_test("a bus");

		// every fourth vector has A equal to B, the next A equal to minus B
		for (int i = 0; i < 12; i++) begin
			bv = rand_word();
			case (i % 4)
				0:       av = bv;
				1:       av = -bv;
				default: av = rand_word();
			endcase
			write_word(bv, 1'b1, 1'b0, 1'b0, 1'b0);
			bus_ctrl.asel = ASEL_L;
			l = av;
			ci = (i % 4 == 1) ? 1'b0 : rand_bit();
			u17 = {1'b0, av} + {1'b0, bv} + 17'(ci);
			s17 = {av[0], av} + {bv[0], bv} + 17'(ci);
			reg_ctrl.apb = 1'b1;
			alu_op("add", FN_ADD, ci, u17[15:0], 1'b1, u17[16], s17[16]);
			reg_ctrl.apb = 1'b0;
			ci = i[0];
			u17 = {1'b0, av} + {1'b0, ~bv} + 17'(ci);
			s17 = {av[0], av} + ~{bv[0], bv} + 17'(ci);
			fn  = FN_SUB;
			cin = ci;
			#1;
			if (!ci) check_bit("sub eq", flags.eq, av == bv);
			reg_ctrl.amb = 1'b1;
			alu_op("sub", FN_SUB, ci, u17[15:0], 1'b1, u17[16], s17[16]);
			reg_ctrl.amb = 1'b0;
			alu_op("xor", FN_XOR, 1'b0, av ^ bv, 1'b0, 1'b0, 1'b0);
			alu_op("and", FN_AND, 1'b0, av & bv, 1'b0, 1'b0, 1'b0);
		end
		end_test("alu and flags");

		l  = rand_word();
		fn = FN_PASS;
		bus_ctrl.asel = ASEL_L;
		at_step(1'b1, 1'b0, 1'b0);
		m_at = l;
		// strob1 outside the as2 phase leaves AT alone
		l = ~l;
		reg_ctrl.at_load = 1'b1;
		strobe.strob1    = 1'b1;
		next_cycle();
		reg_ctrl.at_load = 1'b0;
		strobe           = '0;
		for (int i = 0; i < 6; i++) begin
			fill = rand_bit();
			at_step(1'b0, 1'b1, fill);
			m_at = {fill, m_at[0:14]};
			bus_ctrl.wsel = WSEL_AT;
			reg_ctrl.axy  = 1'b1;
			#1;
			check_word("at shift", w, m_at);
			check_bit("at15", at15, m_at[15]);
			check_bit("exy from at15", exy, m_at[15]);
			reg_ctrl.axy = 1'b0;
			#1;
			check_bit("exy from a0", exy, l[0]);
		end
		// l[0] and l[15] always differ here
		for (int i = 0; i < 4; i++) begin
			l     = {i[1], 14'd0, ~i[1]};
			ir[6] = i[0];
			#1;
			check_bit("exx", flags.exx, i[1] ^ i[0]);
		end
		end_test("at register");

		write_word(16'hfffe, 1'b0, 1'b1, 1'b0, 1'b0);
		check_regs("ar load");
		for (int i = 0; i < 2; i++) begin
			count_step(1'b1, 1'b0, 1'b0, 1'b0, 3'b100);
			m_ar = m_ar + 16'd1;
			check_regs("ar plus one");
		end
		count_step(1'b0, 1'b1, 1'b0, 1'b0, 3'b101);
		m_ar = m_ar - 16'd4;
		check_regs("ar minus four");
		count_step(1'b1, 1'b1, 1'b1, 1'b0, 3'b011);
		check_regs("count without strob1");
		reg_ctrl.arp1 = 1'b1;
		write_word(16'h00a5, 1'b0, 1'b1, 1'b0, 1'b0);
		reg_ctrl.arp1 = 1'b0;
		check_regs("load over count");
		write_word(rand_word(), 1'b0, 1'b0, 1'b1, 1'b1);
		check_regs("ic load");
		count_step(1'b0, 1'b0, 1'b1, 1'b0, 3'b100);
		m_ic = m_ic + 16'd1;
		check_regs("ic plus one");
		bus_ctrl.wsel = WSEL_KL;
		kl = rand_word();
		reg_ctrl.w_ac = 1'b1;
		reg_ctrl.w_ar = 1'b1;
		reg_ctrl.w_ic = 1'b1;
		count_step(1'b0, 1'b0, 1'b0, 1'b0, 3'b010);
		check_regs("write in strob2 without as2");
		count_step(1'b0, 1'b0, 1'b0, 1'b0, 3'b101);
		check_regs("write in strob1 with as2");
		reg_ctrl.w_ac = 1'b0;
		reg_ctrl.w_ar = 1'b0;
		reg_ctrl.w_ic = 1'b0;
		count_step(1'b0, 1'b0, 1'b0, 1'b1, 3'b000);
		m_ic = '0;
		check_regs("ic clear");
		end_test("ar and ic");

		write_word(rand_word(), 1'b0, 1'b1, 1'b0, 1'b0);
		write_word(rand_word(), 1'b0, 1'b0, 1'b1, 1'b1);
		for (int c = 0; c < 8; c++) begin
			reg_ctrl.ar_ad = c[0];
			reg_ctrl.ic_ad = c[1];
			reg_ctrl.barnb = c[2];
			addr = (m_ar & {16{c[0]}}) | (m_ic & {16{c[1]}});
			kl = {c[2], addr[1:15]};
			#1;
			check_word("dad", dad, ~addr);
			check_bit("zga match", zga, 1'b1);
			kl[c] = ~kl[c];
			#1;
			check_bit("zga mismatch", zga, 1'b0);
		end
		next_cycle();
		end_test("address bus");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* pa.f */
+incdir+.
pa_data_pkg.sv
pa_ctrl_pkg.sv
alu181.sv
pa_alu.sv
pa_at_reg.sv
pa_ac_flags.sv
pa_addr_regs.sv
pa_bus.sv
pa.sv
pa_tb.sv

/* Makefile */
all: run

run:
	verilator --binary --timing --assert --top-module pa_tb -f pa.f -o pa_tb
	out="$$(./obj_dir/pa_tb)"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing --top-module pa -f pa.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
